/* mips_periph.f */
mips_bus_pkg.sv
mips_timer_pkg.sv
bus_req_if.sv
pr_req_queue.sv
bridge.sv
timer_counter.sv
dm_port.sv
mips_periph.sv
tb_mips_periph_asserts.sv
tb_mips_periph.sv

/* tb_mips_periph.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_mips_periph
    import mips_bus_pkg::*;
();

    // Cycle budget per test for the watchdog
    localparam int RUN_CYCLES = 800 + 120 + 120 + 120 + 20 + 80 + 400;

    logic    clk = 1'b0;
    logic    rst = 1'b1;
    logic    req_valid = 1'b0;
    addr_t   req_addr = '0;
    word_t   req_wdata = '0;
    byteen_t req_byteen = '0;
    logic    credit_return;
    logic    rsp_valid;
    word_t   rsp_rdata;
    addr_t   m_data_addr;
    word_t   m_data_wdata;
    byteen_t m_data_byteen;
    word_t   m_data_rdata = '0;
    logic    m_data_ready = 1'b1;
    logic    interrupt = 1'b0;
    hw_int_t hw_int;

    logic    stall_en = 1'b0;

    word_t   mem    [4096];
    word_t   shadow [4096];
    word_t   exp_q  [$];

    addr_t   lat_addr;
    word_t   lat_wdata;
    byteen_t lat_be;
    byteen_t seen_be;

    int      issued = 0;
    int      returned = 0;
    int      errors = 0;
    int      failed_tests = 0;
    int      err_mark = 0;
    int      n;

    mips_periph i_dut (.*);
    bind mips_periph tb_mips_periph_asserts i_asserts (
        .clk(clk), .rst(rst), .req_valid(req_valid), .credit_return(credit_return),
        .m_data_byteen(m_data_byteen), .m_data_addr(m_data_addr), .tc1_we(tc1_we),
        .tc_offset(tc_offset), .tc1_irq(tc1_irq), .tc2_irq(tc2_irq),
        .interrupt(interrupt), .hw_int(hw_int));

    initial begin
        forever #5 clk = ~clk;
    end

    function automatic word_t fill_word(input int i);
        return (i * 32'h0001_0003) ^ 32'hA5C3_0000 ^ (i << 20);
    endfunction

    function automatic word_t merge(input word_t old, input word_t nw, input byteen_t be);
        for (int b = 0; b < 4; b++) begin
            if (be[b]) begin
                old[8*b +: 8] = nw[8*b +: 8];
            end
        end
        return old;
    endfunction

    function automatic int failure_total();
        return errors + i_dut.i_asserts.fail_count;
    endfunction

    task automatic check_val(input string name, input word_t exp, input word_t act);
        if (exp !== act) begin
            errors++;
            $display("ERROR %s expected 0x%08h got 0x%08h", name, exp, act);
        end
    endtask

    // External data memory answering one cycle after the address
    always @(negedge clk) begin
        lat_addr  <= m_data_addr;
        lat_wdata <= m_data_wdata;
        lat_be    <= m_data_byteen;
        if (m_data_byteen != '0) begin
            seen_be <= m_data_byteen;
        end
        if (credit_return) begin
            returned++;
        end
        if (!rst && rsp_valid) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("Response arrived with no read outstanding");
            end else begin
                check_val("rsp_rdata", exp_q.pop_front(), rsp_rdata);
            end
        end
    end

    always @(posedge clk) begin
        #1;
        if (lat_be != '0) begin
            mem[lat_addr[13:2]] = merge(mem[lat_addr[13:2]], lat_wdata, lat_be);
        end
        m_data_rdata = mem[lat_addr[13:2]];
        m_data_ready = stall_en ? ($urandom % 4 != 0) : 1'b1;
    end

    // Called at 1 ns after a rising edge
    task automatic send(input addr_t a, input word_t d, input byteen_t be);
        while (issued - returned >= QUEUE_DEPTH) begin
            @(posedge clk);
            #1;
        end
        req_valid  = 1'b1;
        req_addr   = a;
        req_wdata  = d;
        req_byteen = be;
        issued++;
        @(posedge clk);
        #1;
        req_valid = 1'b0;
    endtask

    task automatic bus_read(input addr_t a, input word_t exp);
        exp_q.push_back(exp);
        send(a, '0, '0);
    endtask

    task automatic dm_write(input addr_t a, input word_t d, input byteen_t be);
        shadow[a[13:2]] = merge(shadow[a[13:2]], d, be);
        send(a, d, be);
    endtask

    task automatic drain();
        while (exp_q.size() != 0 || issued != returned) @(negedge clk);
        @(posedge clk);
        #1;
    endtask

    task automatic cycles_to_rise(input int bit_idx, output int cnt);
        cnt = 0;
        do begin
            @(negedge clk);
            cnt++;
        end while (!hw_int[bit_idx]);
    endtask

    task automatic end_test(input string name);
        drain();
        if (failure_total() != err_mark) begin
            failed_tests++;
            $display("test %s: failed", name);
        end else begin
            $display("test %s: ok", name);
        end
        err_mark = failure_total();
    endtask

    initial begin
        #(RUN_CYCLES * 10);
        $display("Watchdog expired, the tests did not finish in %0d cycles", RUN_CYCLES);
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        addr_t rand_addr;

        void'($urandom(51));
        for (int i = 0; i < 4096; i++) begin
            mem[i] = fill_word(i);
            shadow[i] = fill_word(i);
        end
        repeat (3) @(posedge clk);
        #1 rst = 1'b0;

        ////////////////////////////////////////////////
        // Credits under random memory stalls
        stall_en = 1'b1;
        for (int i = 0; i < 60; i++) begin
            rand_addr = addr_t'($urandom % 16) << 2;
            if ($urandom % 2 != 0) begin
                dm_write(rand_addr, $urandom, byteen_t'(($urandom % 15) + 1));
            end else begin
                bus_read(rand_addr, shadow[rand_addr[13:2]]);
            end
        end
        drain();
        stall_en = 1'b0;
        end_test("credits");

        // Data memory path
        dm_write(32'h100, 32'hDEAD_BEEF, 4'hF);
        dm_write(32'h104, 32'h1234_5678, 4'h3);
        drain();
        check_val("m_data_byteen", 32'h3, word_t'(seen_be));
        bus_read(32'h100, 32'hDEAD_BEEF);
        bus_read(32'h104, shadow[32'h104 >> 2]);
        send(32'h7F04, 32'd7, 4'hF);
        bus_read(32'h7F04, 32'd7);
        end_test("dm_path");

        ////////////////////////////////////////////////
        // Timer 1 one-shot with preset 5
        send(32'h7F04, 32'd5, 4'hF);
        drain();
        send(32'h7F00, 32'h9, 4'hF);
        do begin
            @(negedge clk);
        end while (!credit_return);
        cycles_to_rise(0, n);
        check_val("hw_int_delay", 32'd8, word_t'(n));
        repeat (5) @(negedge clk);
        check_val("hw_int", 32'h1, word_t'(hw_int & 6'h1));
        @(posedge clk);
        #1;
        bus_read(32'h7F08, 32'h0);
        bus_read(32'h7F00, 32'h8);
        send(32'h7F00, 32'h0, 4'hF);
        drain();
        repeat (2) @(negedge clk);
        check_val("hw_int", 32'h0, word_t'(hw_int & 6'h1));
        end_test("oneshot");

        // Timer 2 reload with preset 3 and period 5
        send(32'h7F14, 32'd3, 4'hF);
        send(32'h7F10, 32'hB, 4'hF);
        drain();
        cycles_to_rise(1, n);
        for (int p = 0; p < 3; p++) begin
            cycles_to_rise(1, n);
            check_val("tc2_period", 32'd5, word_t'(n));
            check_val("hw_int_tc1", 32'h0, word_t'(hw_int & 6'h1));
        end
        @(posedge clk);
        #1;
        send(32'h7F10, 32'h0, 4'hF);
        end_test("reload");

        // External interrupt into hw_int
        interrupt = 1'b1;
        @(negedge clk);
        check_val("hw_int_ext", 32'h0, word_t'(hw_int & 6'h4));
        @(negedge clk);
        check_val("hw_int_ext", 32'h4, word_t'(hw_int & 6'h4));
        @(posedge clk);
        #1 interrupt = 1'b0;
        repeat (2) @(negedge clk);
        check_val("hw_int", 32'h0, word_t'(hw_int));
        @(posedge clk);
        #1;
        end_test("interrupt");

        ////////////////////////////////////////////////
        // Unmapped addresses
        // 0x5000 aliases DM word 0x1000 in the memory model
        // 0x7F24 lies past timer 2 and carries the PRESET offset bits
        bus_read(32'h5000, 32'h0);
        send(32'h5000, 32'hFFFF_FFFF, 4'hF);
        send(32'h7F24, 32'hFFFF_FFFF, 4'hF);
        bus_read(32'h1000, shadow[32'h1000 >> 2]);
        bus_read(32'h7F04, 32'd5);
        bus_read(32'h7F14, 32'd3);
        end_test("unmapped");

        n = i_dut.i_asserts.fail_count;
        $display("tests: 6, failed: %0d, check errors: %0d, assertion failures: %0d",
                 failed_tests, errors, n);
        if (errors == 0 && n == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb_mips_periph_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_mips_periph_asserts
    import mips_bus_pkg::*;
(
    input logic       clk,
    input logic       rst,
    input logic       req_valid,
    input logic       credit_return,
    input byteen_t    m_data_byteen,
    input addr_t      m_data_addr,
    input logic       tc1_we,
    input logic [1:0] tc_offset,
    input logic       tc1_irq,
    input logic       tc2_irq,
    input logic       interrupt,
    input hw_int_t    hw_int
);

    int fail_count = 0;
    int outstanding;

    // Accepted requests not yet handed back as credits
    always_ff @(posedge clk) begin
        if (rst) begin
            outstanding <= 0;
        end else begin
            outstanding <= outstanding + int'(req_valid) - int'(credit_return);
        end
    end

    a_credit: assert property (@(posedge clk) disable iff (rst)
        (outstanding >= 0) && (outstanding <= QUEUE_DEPTH))
        else begin
            fail_count++;
            $error("credits out of range, more accepted than allowed or more returned than taken");
        end

    a_dm_window: assert property (@(posedge clk) disable iff (rst)
        (m_data_byteen != '0) |-> (m_data_addr <= DM_LIMIT))
        else begin
            fail_count++;
            $error("memory write outside the data window");
        end

    a_hw_int: assert property (@(posedge clk) disable iff (rst)
        !$past(rst) |-> (hw_int[2:0] == $past({interrupt, tc2_irq, tc1_irq})))
        else begin
            fail_count++;
            $error("hw_int does not follow its sources");
        end

    a_hw_int_hi: assert property (@(posedge clk) disable iff (rst)
        hw_int[5:3] == 3'b000)
        else begin
            fail_count++;
            $error("hw_int upper bits not zero");
        end

    // Timer 2 only runs in reload mode here
    a_reload_pulse: assert property (@(posedge clk) disable iff (rst)
        tc2_irq |=> !tc2_irq)
        else begin
            fail_count++;
            $error("reload irq longer than one cycle");
        end

    a_oneshot_hold: assert property (@(posedge clk) disable iff (rst)
        $fell(tc1_irq) |-> $past(tc1_we && (tc_offset == 2'd0)))
        else begin
            fail_count++;
            $error("one-shot irq dropped without a CTRL write");
        end

endmodule

`default_nettype wire

/* mips_periph.sv */
`timescale 1ns/1ps
`default_nettype none

module mips_periph
    import mips_bus_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    // CPU side
    input  logic    req_valid,
    input  addr_t   req_addr,
    input  word_t   req_wdata,
    input  byteen_t req_byteen,
    output logic    credit_return,
    output logic    rsp_valid,
    output word_t   rsp_rdata,
    // Data memory
    output addr_t   m_data_addr,
    output word_t   m_data_wdata,
    output byteen_t m_data_byteen,
    input  word_t   m_data_rdata,
    input  logic    m_data_ready,
    // Interrupts
    input  logic    interrupt,
    output hw_int_t hw_int
);

    logic       mem_stall;
    logic       tc1_we;
    logic       tc2_we;
    logic [1:0] tc_offset;
    word_t      tc_wdata;
    word_t      tc1_rdata;
    word_t      tc2_rdata;
    word_t      dm_rdata;
    logic       tc1_irq;
    logic       tc2_irq;

    bus_req_if u_bus ();

    //////////////////////////////////////////////////
    // Input side
    //////////////////////////////////////////////////
    pr_req_queue i_queue (
        .clk           (clk),
        .rst           (rst),
        .req_valid     (req_valid),
        .req_addr      (req_addr),
        .req_wdata     (req_wdata),
        .req_byteen    (req_byteen),
        .credit_return (credit_return),
        .bus           (u_bus.src)
    );

    //////////////////////////////////////////////////
    // Decode and timers
    //////////////////////////////////////////////////
    bridge i_bridge (
        .clk       (clk),
        .rst       (rst),
        .bus       (u_bus.dec),
        .mem_stall (mem_stall),
        .tc1_we    (tc1_we),
        .tc2_we    (tc2_we),
        .tc_offset (tc_offset),
        .tc_wdata  (tc_wdata),
        .tc1_rdata (tc1_rdata),
        .tc2_rdata (tc2_rdata),
        .dm_rdata  (dm_rdata),
        .rsp_valid (rsp_valid),
        .rsp_rdata (rsp_rdata)
    );

    timer_counter i_tc1 (
        .clk    (clk),
        .rst    (rst),
        .we     (tc1_we),
        .offset (tc_offset),
        .wdata  (tc_wdata),
        .rdata  (tc1_rdata),
        .irq    (tc1_irq)
    );

    timer_counter i_tc2 (
        .clk    (clk),
        .rst    (rst),
        .we     (tc2_we),
        .offset (tc_offset),
        .wdata  (tc_wdata),
        .rdata  (tc2_rdata),
        .irq    (tc2_irq)
    );

    //////////////////////////////////////////////////
    // Output side
    //////////////////////////////////////////////////
    dm_port i_dm (
        .clk           (clk),
        .rst           (rst),
        .bus           (u_bus.mem),
        .mem_stall     (mem_stall),
        .m_data_addr   (m_data_addr),
        .m_data_wdata  (m_data_wdata),
        .m_data_byteen (m_data_byteen),
        .m_data_rdata  (m_data_rdata),
        .m_data_ready  (m_data_ready),
        .dm_rdata      (dm_rdata),
        .tc1_irq       (tc1_irq),
        .tc2_irq       (tc2_irq),
        .interrupt     (interrupt),
        .hw_int        (hw_int)
    );

endmodule

`default_nettype wire

/* dm_port.sv */
`timescale 1ns/1ps
`default_nettype none

module dm_port
    import mips_bus_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    bus_req_if.mem  bus,
    output logic    mem_stall,
    output addr_t   m_data_addr,
    output word_t   m_data_wdata,
    output byteen_t m_data_byteen,
    input  word_t   m_data_rdata,
    input  logic    m_data_ready,
    output word_t   dm_rdata,
    input  logic    tc1_irq,
    input  logic    tc2_irq,
    input  logic    interrupt,
    output hw_int_t hw_int
);

    logic    dm_go;
    logic    rd_back;
    word_t   rdata_q;
    hw_int_t hw_int_d;

    //////////////////////////////////////////////////
    // Memory request
    //////////////////////////////////////////////////
    // Same condition as the bridge handshake for a DM request
    assign dm_go     = bus.valid && (bus.sel == DEV_DM) && m_data_ready;
    assign mem_stall = !m_data_ready;

    assign m_data_addr   = bus.addr;
    assign m_data_wdata  = bus.wdata;
    assign m_data_byteen = dm_go ? bus.byteen : '0;

    //////////////////////////////////////////////////
    // Read return
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_back <= 1'b0;
        end else begin
            rd_back <= dm_go && (bus.byteen == '0);
        end
    end

    // Keep the last returned word stable
    always_ff @(posedge clk) begin
        if (rd_back) begin
            rdata_q <= m_data_rdata;
        end
    end

    assign dm_rdata = rd_back ? m_data_rdata : rdata_q;

    //////////////////////////////////////////////////
    // Interrupt vector
    //////////////////////////////////////////////////
    always_comb begin
        hw_int_d             = '0;
        hw_int_d[HW_INT_TC1] = tc1_irq;
        hw_int_d[HW_INT_TC2] = tc2_irq;
        hw_int_d[HW_INT_EXT] = interrupt;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            hw_int <= '0;
        end else begin
            hw_int <= hw_int_d;
        end
    end

endmodule

`default_nettype wire

/* timer_counter.sv */
`timescale 1ns/1ps
`default_nettype none

module timer_counter
    import mips_bus_pkg::*;
    import mips_timer_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       we,
    input  logic [1:0] offset,
    input  word_t      wdata,
    output word_t      rdata,
    output logic       irq
);

    word_t     ctrl;
    word_t     preset;
    word_t     count;
    tc_state_t state;

    logic      ctrl_wr;
    logic      preset_wr;
    tc_mode_t  mode;

    assign ctrl_wr   = we && (offset == TC_CTRL);
    assign preset_wr = we && (offset == TC_PRESET);
    assign mode      = tc_mode_t'(ctrl[CTRL_MODE_HI:CTRL_MODE_LO]);

    //////////////////////////////////////////////////
    // Counter FSM and registers
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            ctrl   <= '0;
            preset <= '0;
            count  <= '0;
            state  <= TC_IDLE;
        end else begin
            case (state)
                TC_IDLE: begin
                    if (ctrl[CTRL_EN]) begin
                        state <= TC_LOAD;
                    end
                end
                TC_LOAD: begin
                    count <= preset;
                    state <= TC_CNT;
                end
                TC_CNT: begin
                    if (!ctrl[CTRL_EN]) begin
                        state <= TC_IDLE;
                    end else if (count <= 32'd1) begin
                        // Last tick lands on zero
                        count <= '0;
                        state <= TC_INT;
                    end else begin
                        count <= count - 1'b1;
                    end
                end
                TC_INT: begin
                    if (mode == MODE_RELOAD) begin
                        state <= TC_LOAD;
                    end else begin
                        // One-shot parks here until CTRL is rewritten
                        ctrl[CTRL_EN] <= 1'b0;
                    end
                end
                default: state <= TC_IDLE;
            endcase

            // Bus writes take priority over the FSM
            if (preset_wr) begin
                preset <= wdata;
            end
            if (ctrl_wr) begin
                ctrl  <= wdata & CTRL_MASK;
                state <= wdata[CTRL_EN] ? TC_LOAD : TC_IDLE;
            end
        end
    end

    // Reload mode stays one cycle in TC_INT, giving a pulse
    assign irq = (state == TC_INT) && ctrl[CTRL_IM];

    //////////////////////////////////////////////////
    // Register read
    //////////////////////////////////////////////////
    always_comb begin
        case (offset)
            TC_CTRL:   rdata = ctrl;
            TC_PRESET: rdata = preset;
            TC_COUNT:  rdata = count;
            default:   rdata = '0;
        endcase
    end

endmodule

`default_nettype wire

/* bridge.sv */
`timescale 1ns/1ps
`default_nettype none

module bridge
    import mips_bus_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    bus_req_if.dec     bus,
    input  logic       mem_stall,
    output logic       tc1_we,
    output logic       tc2_we,
    output logic [1:0] tc_offset,
    output word_t      tc_wdata,
    input  word_t      tc1_rdata,
    input  word_t      tc2_rdata,
    input  word_t      dm_rdata,
    output logic       rsp_valid,
    output word_t      rsp_rdata
);

    dev_sel_t dev;
    logic     hs;
    logic     is_write;
    logic     rd_hs;

    // Record of the read in flight
    logic     pend_valid;
    dev_sel_t pend_dev;
    word_t    pend_tc_rdata;

    function automatic logic in_timer(input addr_t a, input addr_t base);
        return (a >= base) && (a < base + TC_SPAN);
    endfunction

    //////////////////////////////////////////////////
    // Address decode
    //////////////////////////////////////////////////
    always_comb begin
        if (bus.addr >= DM_BASE && bus.addr <= DM_LIMIT) begin
            dev = DEV_DM;
        end else if (in_timer(bus.addr, TC1_BASE)) begin
            dev = DEV_TC1;
        end else if (in_timer(bus.addr, TC2_BASE)) begin
            dev = DEV_TC2;
        end else begin
            dev = DEV_NONE;
        end
    end

    assign bus.sel   = dev;
    // Only DM requests wait on the memory
    assign bus.ready = !(dev == DEV_DM && mem_stall);

    assign hs       = bus.valid && bus.ready;
    assign is_write = |bus.byteen;
    assign rd_hs    = hs && !is_write;

    // Timer write steering
    assign tc1_we    = hs && is_write && (dev == DEV_TC1);
    assign tc2_we    = hs && is_write && (dev == DEV_TC2);
    assign tc_offset = bus.addr[3:2];
    assign tc_wdata  = bus.wdata;

    //////////////////////////////////////////////////
    // Read response
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            pend_valid <= 1'b0;
        end else begin
            pend_valid <= rd_hs;
        end
    end

    // Timer data is captured at the handshake, DM data arrives next cycle
    always_ff @(posedge clk) begin
        if (rd_hs) begin
            pend_dev      <= dev;
            pend_tc_rdata <= (dev == DEV_TC2) ? tc2_rdata : tc1_rdata;
        end
    end

    always_comb begin
        case (pend_dev)
            DEV_DM:           rsp_rdata = dm_rdata;
            DEV_TC1, DEV_TC2: rsp_rdata = pend_tc_rdata;
            default:          rsp_rdata = '0;
        endcase
    end

    assign rsp_valid = pend_valid;

endmodule

`default_nettype wire

/* pr_req_queue.sv */
`timescale 1ns/1ps
`default_nettype none

module pr_req_queue
    import mips_bus_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    req_valid,
    input  addr_t   req_addr,
    input  word_t   req_wdata,
    input  byteen_t req_byteen,
    output logic    credit_return,
    bus_req_if.src  bus
);

    // Entry storage
    addr_t   addr_mem   [QUEUE_DEPTH];
    word_t   wdata_mem  [QUEUE_DEPTH];
    byteen_t byteen_mem [QUEUE_DEPTH];

    logic [QPTR_W-1:0] wr_ptr;
    logic [QPTR_W-1:0] rd_ptr;
    credit_t           count;

    logic push;
    logic pop;

    // Requester only pushes while holding a credit
    assign push = req_valid;
    assign pop  = bus.valid && bus.ready;

    //////////////////////////////////////////////////
    // Storage write
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (push) begin
            addr_mem[wr_ptr]   <= req_addr;
            wdata_mem[wr_ptr]  <= req_wdata;
            byteen_mem[wr_ptr] <= req_byteen;
        end
    end

    //////////////////////////////////////////////////
    // Pointers and occupancy
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Head of queue
    assign bus.valid  = (count != '0);
    assign bus.addr   = addr_mem[rd_ptr];
    assign bus.wdata  = wdata_mem[rd_ptr];
    assign bus.byteen = byteen_mem[rd_ptr];

    // One credit back per entry leaving
    assign credit_return = pop;

endmodule

`default_nettype wire

/* bus_req_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface bus_req_if
    import mips_bus_pkg::*;
();

    logic     valid;
    logic     ready;
    addr_t    addr;
    word_t    wdata;
    byteen_t  byteen;
    dev_sel_t sel;

    // Queue head
    modport src (
        output valid,
        output addr,
        output wdata,
        output byteen,
        input  ready
    );

    // Bridge decodes the head and accepts it
    modport dec (
        input  valid,
        input  addr,
        input  wdata,
        input  byteen,
        output ready,
        output sel
    );

    // Memory port only observes
    modport mem (
        input valid,
        input addr,
        input wdata,
        input byteen,
        input sel
    );

endinterface

`default_nettype wire

/* mips_timer_pkg.sv */
`default_nettype none

package mips_timer_pkg;

    //////////////////////////////////////////////////
    // Register map, word offsets
    //////////////////////////////////////////////////
    localparam logic [1:0] TC_CTRL   = 2'd0;
    localparam logic [1:0] TC_PRESET = 2'd1;
    localparam logic [1:0] TC_COUNT  = 2'd2;

    // Control register fields
    localparam int CTRL_EN      = 0;
    localparam int CTRL_MODE_LO = 1;
    localparam int CTRL_MODE_HI = 2;
    localparam int CTRL_IM      = 3;

    // Only the low four control bits exist
    localparam logic [31:0] CTRL_MASK = 32'h0000_000F;

    typedef enum logic [1:0] {
        MODE_ONESHOT = 2'd0,
        MODE_RELOAD  = 2'd1
    } tc_mode_t;

    // TC_CNT is the counting state, TC_COUNT is taken by the register offset
    typedef enum logic [1:0] {
        TC_IDLE,
        TC_LOAD,
        TC_CNT,
        TC_INT
    } tc_state_t;

endpackage

`default_nettype wire

/* mips_bus_pkg.sv */
`default_nettype none

package mips_bus_pkg;

    //////////////////////////////////////////////////
    // Bus widths
    //////////////////////////////////////////////////
    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;
    typedef logic [3:0]  byteen_t;
    typedef logic [5:0]  hw_int_t;
    typedef logic [2:0]  credit_t;

    // Request queue size
    localparam int QUEUE_DEPTH = 4;
    localparam int QPTR_W      = $clog2(QUEUE_DEPTH);

    //////////////////////////////////////////////////
    // Address map
    //////////////////////////////////////////////////
    localparam addr_t DM_BASE  = 32'h0000_0000;
    localparam addr_t DM_LIMIT = 32'h0000_2FFF;
    localparam addr_t TC1_BASE = 32'h0000_7F00;
    localparam addr_t TC2_BASE = 32'h0000_7F10;
    // Three word registers per timer
    localparam addr_t TC_SPAN  = 32'd12;

    // Positions inside hw_int
    localparam int HW_INT_TC1 = 0;
    localparam int HW_INT_TC2 = 1;
    localparam int HW_INT_EXT = 2;

    typedef enum logic [1:0] {
        DEV_DM,
        DEV_TC1,
        DEV_TC2,
        DEV_NONE
    } dev_sel_t;

endpackage

`default_nettype wire
